//--- flist.f
src/rom_pkg.sv
src/rpwp_ram.sv
src/bram_rom.sv
src/rom_dwnld.sv
src/rom_fetch.sv
src/rom_sub.sv
dv/rom_sub_tb.sv

//--- Makefile
# Verilator build for the ROM subsystem

TOP = rom_sub_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

obj_dir/$(TOP): flist.f src/*.sv dv/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)

# The log decides pass or fail
sim: obj_dir/$(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/rom_sub_tb.sv
// ROM subsystem testbench
`default_nettype none

module rom_sub_tb
    import rom_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int main_aw    = 10;
    localparam int gfx_aw     = 9;
    localparam int gfx_offset = 1024;
    localparam int main_size  = 2 ** main_aw;
    localparam int gfx_size   = 2 ** gfx_aw;

    logic        clk;
    logic        reset;
    logic        ioctl_downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        rd_req;
    rom_region_e rd_region;
    logic [9:0]  rd_addr;
    logic        rd_ack;
    logic [15:0] rd_data;
    logic        rom_ready;

    // Reference contents of both ROMs
    logic [7:0]  main_ref [0:main_size-1];
    logic [15:0] gfx_ref  [0:gfx_size-1];

    // Expected ready level and read pipeline
    logic        m_ready;
    logic        m_loading;
    logic        m_got;
    logic        acc1;
    logic        acc2;
    rom_region_e reg1;
    logic [9:0]  addr1;
    logic [15:0] exp2;

    int seed;
    int err_count;
    int ack_count;
    int test_count;
    int test_err_base;

    rom_sub #(
        .main_aw    (main_aw),
        .gfx_aw     (gfx_aw),
        .gfx_offset (gfx_offset)
    ) rom_sub_i (
        .clk               (clk),
        .reset             (reset),
        .ioctl_downloading (ioctl_downloading),
        .ioctl_addr        (ioctl_addr),
        .ioctl_dout        (ioctl_dout),
        .ioctl_wr          (ioctl_wr),
        .rd_req            (rd_req),
        .rd_region         (rd_region),
        .rd_addr           (rd_addr),
        .rd_ack            (rd_ack),
        .rd_data           (rd_data),
        .rom_ready         (rom_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Download byte pattern
    // The second load uses another mix
    function automatic logic [7:0] pattern_byte(input int b, input logic second);
        if (second) begin
            return 8'(b * 13) ^ 8'ha5;
        end
        return 8'(b * 7) ^ 8'h5a;
    endfunction

    // Predicted reply for a read
    function automatic logic [15:0] expected_word(input rom_region_e region,
                                                  input logic [9:0] addr);
        if (region == region_main) begin
            return {8'h00, main_ref[addr[main_aw-1:0]]};
        end
        return gfx_ref[addr[gfx_aw-1:0]];
    endfunction

    // Window rule on halfword address b/2
    // Lane picked by the odd bit
    task automatic update_ref(input int b, input logic [7:0] d);
        int h;
        h = b / 2;
        if (h < main_size / 2) begin
            main_ref[2 * h + (b % 2)] = d;
        end else if (h >= gfx_offset && h < gfx_offset + gfx_size) begin
            if (b % 2 == 0) begin
                gfx_ref[h - gfx_offset][7:0] = d;
            end else begin
                gfx_ref[h - gfx_offset][15:8] = d;
            end
        end
    endtask

    // Ready rises after a load with bytes and falls once a new load starts
    always @(posedge clk) begin
        if (reset) begin
            m_ready   <= 1'b0;
            m_loading <= 1'b0;
            m_got     <= 1'b0;
            acc1      <= 1'b0;
            acc2      <= 1'b0;
        end else begin
            if (ioctl_downloading) begin
                m_ready   <= 1'b0;
                m_loading <= 1'b1;
                m_got     <= (m_loading && m_got) || ioctl_wr;
            end else if (m_loading) begin
                m_loading <= 1'b0;
                m_ready   <= m_got || ioctl_wr;
            end
            // Two-cycle read latency
            acc1  <= rd_req && m_ready;
            reg1  <= rd_region;
            addr1 <= rd_addr;
            acc2  <= acc1;
            exp2  <= expected_word(reg1, addr1);
        end
    end

    always @(negedge clk) begin
        if (rd_ack) begin
            ack_count++;
        end
    end

    a_ready_level: assert property (
        @(posedge clk) disable iff (reset) rom_ready === m_ready
    ) else begin
        err_count++;
        $display("** Error rom_ready: expected %h, got %h", $sampled(m_ready),
                 $sampled(rom_ready));
    end

    a_ack_timing: assert property (
        @(posedge clk) disable iff (reset) rd_ack === acc2
    ) else begin
        err_count++;
        $display("** Error rd_ack: expected %h, got %h", $sampled(acc2), $sampled(rd_ack));
    end

    a_read_data: assert property (
        @(posedge clk) disable iff (reset) acc2 |-> rd_data === exp2
    ) else begin
        err_count++;
        $display("** Error rd_data: expected %h, got %h", $sampled(exp2), $sampled(rd_data));
    end

    // Holds the request for one cycle from a falling edge
    task automatic drive_read(input rom_region_e region, input int addr);
        rd_req    = 1'b1;
        rd_region = region;
        rd_addr   = 10'(addr);
        @(negedge clk);
    endtask

    task automatic drain_reads();
        rd_req = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic issue_random_reads(input int n);
        int r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            drive_read(r[10] ? region_gfx : region_main, int'(r[9:0]));
        end
        drain_reads();
    endtask

    // One byte per cycle with optional reads alongside
    task automatic download(input int lo, input int hi, input logic second,
                            input logic with_reads);
        logic [7:0] d;
        ioctl_downloading = 1'b1;
        ioctl_wr          = 1'b0;
        @(negedge clk);
        for (int b = lo; b <= hi; b++) begin
            d          = pattern_byte(b, second);
            ioctl_addr = 25'(b);
            ioctl_dout = d;
            ioctl_wr   = 1'b1;
            update_ref(b, d);
            rd_req     = with_reads;
            rd_region  = (b % 2 == 1) ? region_gfx : region_main;
            rd_addr    = 10'(b);
            @(negedge clk);
        end
        ioctl_wr = 1'b0;
        rd_req   = 1'b0;
        @(negedge clk);
        ioctl_downloading = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (rom_ready !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rom_ready !== 1'b1) begin
            err_count++;
            $display("rom_ready did not rise within 20 cycles of the download end");
        end
    endtask

    task automatic read_all_main();
        for (int a = 0; a < main_size; a++) begin
            drive_read(region_main, a);
        end
        drain_reads();
    endtask

    task automatic read_all_gfx();
        for (int a = 0; a < gfx_size; a++) begin
            drive_read(region_gfx, a);
        end
        drain_reads();
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name,
                 (err_count == test_err_base) ? "ok" : "FAILED", err_count - test_err_base);
        test_err_base = err_count;
    endtask

    initial begin
        seed              = 32'he573;
        err_count         = 0;
        ack_count         = 0;
        test_count        = 0;
        test_err_base     = 0;
        reset             = 1'b1;
        ioctl_downloading = 1'b0;
        ioctl_addr        = '0;
        ioctl_dout        = '0;
        ioctl_wr          = 1'b0;
        rd_req            = 1'b0;
        rd_region         = region_main;
        rd_addr           = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Reads before and during the first load are refused
        issue_random_reads(16);
        download(0, 3071, 1'b0, 1'b1);
        finish_test("reset and refused reads");

        wait_ready();
        read_all_main();
        finish_test("main readback");

        read_all_gfx();
        finish_test("gfx readback");

        // Bytes 1024 to 2047 land in neither window
        download(1024, 2047, 1'b1, 1'b1);
        wait_ready();
        read_all_main();
        read_all_gfx();
        finish_test("out of window load");

        issue_random_reads(2000);
        finish_test("random back-to-back reads");

        $display("tests %0d, reads acknowledged %0d, errors %0d", test_count, ack_count,
                 err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/rom_sub.sv
// Downloadable ROM subsystem
`default_nettype none

module rom_sub
    import rom_pkg::*;
#(
    parameter int main_aw    = 10,
    parameter int gfx_aw     = 9,
    parameter int gfx_offset = 1024
) (
    input  wire         clk,
    input  wire         reset,

    // Download stream
    input  wire         ioctl_downloading,
    input  wire  [24:0] ioctl_addr,
    input  wire  [7:0]  ioctl_dout,
    input  wire         ioctl_wr,

    // Read side
    input  wire         rd_req,
    input  rom_region_e rd_region,
    input  wire  [9:0]  rd_addr,
    output logic        rd_ack,
    output logic [15:0] rd_data,

    output logic        rom_ready
);

    // Programming bus
    logic [prog_aw-1:0] prog_addr;
    logic [1:0]         prog_mask;
    logic [7:0]         prog_data;
    logic               prog_we;

    // ROM read ports
    logic [main_aw-1:0] main_addr;
    logic [7:0]         main_data;
    logic [gfx_aw-1:0]  gfx_addr;
    logic [15:0]        gfx_data;

    rom_dwnld u_dwnld (
        .clk               (clk),
        .reset             (reset),
        .ioctl_downloading (ioctl_downloading),
        .ioctl_addr        (ioctl_addr),
        .ioctl_dout        (ioctl_dout),
        .ioctl_wr          (ioctl_wr),
        .prog_addr         (prog_addr),
        .prog_mask         (prog_mask),
        .prog_data         (prog_data),
        .prog_we           (prog_we),
        .rom_ready         (rom_ready)
    );

    // Byte ROM at the start of the download
    bram_rom #(
        .dw     (8),
        .aw     (main_aw),
        .offset (0)
    ) u_main (
        .clk       (clk),
        .addr      (main_addr),
        .data      (main_data),
        .prog_addr (prog_addr),
        .prog_mask (prog_mask),
        .prog_data (prog_data),
        .prog_we   (prog_we)
    );

    // Halfword ROM further up the download
    bram_rom #(
        .dw     (16),
        .aw     (gfx_aw),
        .offset (gfx_offset)
    ) u_gfx (
        .clk       (clk),
        .addr      (gfx_addr),
        .data      (gfx_data),
        .prog_addr (prog_addr),
        .prog_mask (prog_mask),
        .prog_data (prog_data),
        .prog_we   (prog_we)
    );

    rom_fetch #(
        .main_aw (main_aw),
        .gfx_aw  (gfx_aw)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .rom_ready (rom_ready),
        .rd_req    (rd_req),
        .rd_region (rd_region),
        .rd_addr   (rd_addr),
        .main_addr (main_addr),
        .main_data (main_data),
        .gfx_addr  (gfx_addr),
        .gfx_data  (gfx_data),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

//--- src/rom_fetch.sv
// Region-tagged ROM read pipeline
`default_nettype none

module rom_fetch
    import rom_pkg::*;
#(
    parameter int main_aw = 10,
    parameter int gfx_aw  = 9
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                rom_ready,

    // Read requests
    input  wire                rd_req,
    input  rom_region_e        rd_region,
    input  wire  [9:0]         rd_addr,

    // ROM read ports
    output logic [main_aw-1:0] main_addr,
    input  wire  [7:0]         main_data,
    output logic [gfx_aw-1:0]  gfx_addr,
    input  wire  [15:0]        gfx_data,

    // Replies
    output logic               rd_ack,
    output logic [15:0]        rd_data
);

    logic        accept;
    logic        s1_valid;
    logic        s2_valid;
    rom_region_e s1_region;
    rom_region_e s2_region;

    // Requests are ignored until the ROMs hold data
    assign accept = rd_req && rom_ready;

    // Stage 1 address register, feeds the RAM read port
    // Only the chosen ROM sees a new address
    always_ff @(posedge clk) begin
        if (accept) begin
            if (rd_region == region_main) begin
                main_addr <= rd_addr[main_aw-1:0];
            end else begin
                gfx_addr <= rd_addr[gfx_aw-1:0];
            end
        end
    end

    // Region tag follows the request down the pipe
    always_ff @(posedge clk) begin
        s1_region <= rd_region;
        s2_region <= s1_region;
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    // Stage 2 lines up with the RAM output
    assign rd_ack  = s2_valid;
    // Main data is zero-extended into the low byte
    assign rd_data = (s2_region == region_main) ? {8'h00, main_data} : gfx_data;

    // Every ack traces back to an accepted request
    a_ack_has_req: assert property (
        @(posedge clk) disable iff (reset)
        rd_ack |-> $past(accept, 2)
    ) else $error("rom_fetch: rd_ack without a request two cycles earlier");

endmodule

`default_nettype wire

//--- src/rom_dwnld.sv
// Download stream to programming bus
`default_nettype none

module rom_dwnld
    import rom_pkg::*;
(
    input  wire                clk,
    input  wire                reset,

    // Byte-wide download stream
    input  wire                ioctl_downloading,
    input  wire [24:0]         ioctl_addr,
    input  wire [7:0]          ioctl_dout,
    input  wire                ioctl_wr,

    // Halfword programming bus
    output logic [prog_aw-1:0] prog_addr,
    output logic [1:0]         prog_mask,
    output logic [7:0]         prog_data,
    output logic               prog_we,

    // High once a load with data has completed
    output logic               rom_ready
);

    dwnld_state_e state;
    // Set by any byte seen during the current load
    logic         got_byte;

    // Payload registers, one cycle behind the strobe
    always_ff @(posedge clk) begin
        // Halfword address drops the byte select bit
        prog_addr <= ioctl_addr[prog_aw:1];
        // Active-low mask, zero marks the lane written
        // Even byte goes to the low lane
        prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        prog_data <= ioctl_dout;
    end

    // Write strobe follows ioctl_wr by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= ioctl_wr;
        end
    end

    // Load tracking FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            got_byte <= 1'b0;
        end else begin
            case (state)
                st_idle, st_ready: begin
                    // A new load restarts the byte count
                    if (ioctl_downloading) begin
                        state    <= st_loading;
                        got_byte <= ioctl_wr;
                    end
                end
                st_loading: begin
                    if (ioctl_wr) begin
                        got_byte <= 1'b1;
                    end
                    if (!ioctl_downloading) begin
                        // An empty load leaves nothing to serve
                        state <= (got_byte || ioctl_wr) ? st_ready : st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign rom_ready = (state == st_ready);

    // Exactly one lane selected on every write
    a_mask_one_lane: assert property (
        @(posedge clk) disable iff (reset)
        prog_we |-> (prog_mask == 2'b01 || prog_mask == 2'b10)
    ) else $error("rom_dwnld: prog_mask %b on a write", prog_mask);

endmodule

`default_nettype wire

//--- src/bram_rom.sv
// Block RAM ROM with programming port
`default_nettype none

module bram_rom
    import rom_pkg::*;
#(
    parameter int dw     = 8,
    parameter int aw     = 10,
    // Halfword offset of the window on the programming bus
    parameter int offset = 0
) (
    input  wire                clk,

    // Read port
    input  wire  [aw-1:0]      addr,
    output logic [dw-1:0]      data,

    // Programming bus from the download side
    input  wire  [prog_aw-1:0] prog_addr,
    input  wire  [1:0]         prog_mask,
    input  wire  [7:0]         prog_data,
    input  wire                prog_we
);

    // Window size in halfwords
    // A byte ROM of 2^aw bytes spans half as many halfwords
    localparam int win_size = (dw == 8) ? 2 ** (aw - 1) : 2 ** aw;
    localparam logic [prog_aw-1:0] win_base = prog_aw'(offset);
    localparam logic [prog_aw-1:0] win_len  = prog_aw'(win_size);

    logic [prog_aw-1:0] prog_aeff;
    logic               in_range;

    // Address relative to the window start
    assign prog_aeff = prog_addr - win_base;
    // Addresses below the base wrap high and fail the check too
    assign in_range = (prog_aeff < win_len);

    if (dw == 8) begin : g_byte
        logic ram_we;

        assign ram_we = prog_we && in_range;

        // Byte address is the halfword plus the odd bit
        // mask[0] is set only for the odd byte
        rpwp_ram #(
            .dw (dw),
            .aw (aw)
        ) u_ram (
            .clk     (clk),
            .rd_addr (addr),
            .dout    (data),
            .wr_addr ({prog_aeff[aw-2:0], prog_mask[0]}),
            .din     (prog_data),
            .we      (ram_we)
        );
    end else if (dw == 16) begin : g_word
        // Lane 0 is the lower byte, lane 1 the upper byte
        for (genvar i = 0; i < 2; i++) begin : g_lane
            logic lane_we;

            // Active-low mask picks the lane
            assign lane_we = prog_we && in_range && !prog_mask[i];

            rpwp_ram #(
                .dw (8),
                .aw (aw)
            ) u_ram (
                .clk     (clk),
                .rd_addr (addr),
                .dout    (data[8*i +: 8]),
                .wr_addr (prog_aeff[aw-1:0]),
                .din     (prog_data),
                .we      (lane_we)
            );
        end
    end else begin : g_bad_dw
        $error("bram_rom: dw must be 8 or 16, got %0d", dw);
    end

endmodule

`default_nettype wire

//--- src/rpwp_ram.sv
// Single read single write block RAM
`default_nettype none

module rpwp_ram #(
    parameter int dw = 8,
    parameter int aw = 10
) (
    input  wire           clk,

    // Read port, data one cycle after the address
    input  wire  [aw-1:0] rd_addr,
    output logic [dw-1:0] dout,

    // Write port
    input  wire  [aw-1:0] wr_addr,
    input  wire  [dw-1:0] din,
    input  wire           we
);

    // Storage array, inferred as block RAM
    logic [dw-1:0] mem [0:(2**aw)-1];

    // Registered read
    // Same-cycle collision returns the old word
    always_ff @(posedge clk) begin
        dout <= mem[rd_addr];
    end

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

endmodule

`default_nettype wire

//--- src/rom_pkg.sv
// ROM subsystem shared definitions
`default_nettype none

package rom_pkg;

    // Width of the halfword programming address
    // 24 bits of halfword cover a 32 MB byte space
    localparam int prog_aw = 24;

    // Region tag carried with every read request
    // Main is the byte-wide ROM, gfx the halfword ROM
    typedef enum logic {
        region_main = 1'b0,
        region_gfx  = 1'b1
    } rom_region_e;

    // Download tracker states
    // Idle until the first load starts
    // Loading while the downloading level is high
    // Ready once a load with data has finished
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_loading = 2'd1,
        st_ready   = 2'd2
    } dwnld_state_e;

endpackage

`default_nettype wire
